// File: spi_defines.svh
// Bus widths and AXI response codes for the SPI master, included by RTL and testbench
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// AXI4-Lite address width, enough for the five register offsets
`define SPI_ADDR_WIDTH 4

// Register width and SPI byte width
`define SPI_DATA_WIDTH 8

// Strobe width follows the data width
`define SPI_STRB_WIDTH (`SPI_DATA_WIDTH / 8)

// AXI response codes
`define SPI_RESP_OKAY   2'b00
`define SPI_RESP_SLVERR 2'b10

// Bit positions in the STATUS register
`define SPI_STATUS_DONE_BIT 0
`define SPI_STATUS_BUSY_BIT 1

// Start request bit in the CTRL register
`define SPI_CTRL_START_BIT 0

`endif

// File: spi_pkg.sv
// Shared types for the SPI master, referenced by scoped name from RTL and testbench
`include "spi_defines.svh"

package spi_pkg;

    // Register offsets on the AXI4-Lite bus
    typedef enum logic [`SPI_ADDR_WIDTH-1:0] {
        REG_TX_DATA = 4'd0,
        REG_MODE    = 4'd1,
        REG_CTRL    = 4'd2,
        REG_RX_DATA = 4'd3,
        REG_STATUS  = 4'd4
    } reg_addr_e;

    // Transfer modes, encoding 3 runs as single
    typedef enum logic [1:0] {
        MODE_SINGLE  = 2'd0,
        MODE_DUAL_TX = 2'd1,
        MODE_DUAL_RX = 2'd2
    } spi_mode_e;

    typedef enum logic [1:0] {
        WR_IDLE   = 2'd0,
        WR_COMMIT = 2'd1,
        WR_RESP   = 2'd2
    } axi_wr_state_e;

    typedef enum logic [1:0] {
        RD_IDLE  = 2'd0,
        RD_FETCH = 2'd1,
        RD_RESP  = 2'd2
    } axi_rd_state_e;

    typedef enum logic {
        SPI_IDLE  = 1'b0,
        SPI_SHIFT = 1'b1
    } spi_state_e;

    // Register block to engine
    typedef struct packed {
        logic [`SPI_DATA_WIDTH-1:0] tx_data;
        spi_mode_e                  mode;
        logic                       start;
    } spi_cmd_t;

    // Engine to register block, done pulses for one cycle
    typedef struct packed {
        logic [`SPI_DATA_WIDTH-1:0] rx_data;
        logic                       done;
        logic                       busy;
    } spi_status_t;

endpackage

// File: axi_lite_regs.sv
// AXI4-Lite slave holding the SPI control registers, drives the engine command
`timescale 1ns/1ns
`include "spi_defines.svh"

module axi_lite_regs (
    input  logic                       axi_aclk,
    input  logic                       axi_aresetn,

    input  logic [`SPI_ADDR_WIDTH-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,

    input  logic [`SPI_DATA_WIDTH-1:0] wdata,
    input  logic [`SPI_STRB_WIDTH-1:0] wstrb,
    input  logic                       wvalid,
    output logic                       wready,

    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,

    input  logic [`SPI_ADDR_WIDTH-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,

    output logic [`SPI_DATA_WIDTH-1:0] rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,

    input  spi_pkg::spi_status_t       status,
    output spi_pkg::spi_cmd_t          cmd
);

    spi_pkg::axi_wr_state_e     wr_state;
    spi_pkg::axi_rd_state_e     rd_state;
    logic [`SPI_ADDR_WIDTH-1:0] awaddr_q;
    logic [`SPI_DATA_WIDTH-1:0] wdata_q;
    logic [`SPI_ADDR_WIDTH-1:0] araddr_q;
    logic [`SPI_DATA_WIDTH-1:0] tx_data_q;
    spi_pkg::spi_mode_e         mode_q;
    logic                       start_req;
    logic                       start_q;
    logic                       done_sticky;
    logic                       wr_mapped;
    logic                       rd_mapped;

    // Offsets past STATUS are unmapped
    assign wr_mapped = (awaddr_q <= spi_pkg::REG_STATUS);
    assign rd_mapped = (araddr_q <= spi_pkg::REG_STATUS);

    // Write channel, address and data must arrive together
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            wr_state  <= spi_pkg::WR_IDLE;
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            bresp     <= `SPI_RESP_OKAY;
            tx_data_q <= '0;
            mode_q    <= spi_pkg::MODE_SINGLE;
            start_req <= 1'b0;
        end else begin
            start_req <= 1'b0;
            case (wr_state)
                spi_pkg::WR_IDLE: begin
                    awready <= 1'b1;
                    wready  <= 1'b1;
                    if (awvalid && wvalid && awready && wready) begin
                        awready  <= 1'b0;
                        wready   <= 1'b0;
                        wr_state <= spi_pkg::WR_COMMIT;
                    end
                end
                spi_pkg::WR_COMMIT: begin
                    case (spi_pkg::reg_addr_e'(awaddr_q))
                        spi_pkg::REG_TX_DATA: tx_data_q <= wdata_q;
                        spi_pkg::REG_MODE:    mode_q <= spi_pkg::spi_mode_e'(wdata_q[1:0]);
                        spi_pkg::REG_CTRL:    start_req <= wdata_q[`SPI_CTRL_START_BIT];
                        default: ;
                    endcase
                    bresp    <= wr_mapped ? `SPI_RESP_OKAY : `SPI_RESP_SLVERR;
                    wr_state <= spi_pkg::WR_RESP;
                end
                spi_pkg::WR_RESP: begin
                    // One cycle gap after commit, then hold until accepted
                    if (!bvalid) begin
                        bvalid <= 1'b1;
                    end else if (bready) begin
                        bvalid   <= 1'b0;
                        wr_state <= spi_pkg::WR_IDLE;
                    end
                end
                default: wr_state <= spi_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (wr_state == spi_pkg::WR_IDLE && awvalid && wvalid && awready && wready) begin
            awaddr_q <= awaddr;
            wdata_q  <= wdata;
        end
    end

    // Start goes out one edge after the CTRL commit, dropped while busy
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            start_q     <= 1'b0;
            done_sticky <= 1'b0;
        end else begin
            start_q <= start_req && !status.busy;
            if (start_q) begin
                done_sticky <= 1'b0;
            end else if (status.done) begin
                done_sticky <= 1'b1;
            end
        end
    end

    assign cmd = '{tx_data: tx_data_q, mode: mode_q, start: start_q};

    // Read channel, independent of the write side
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            rd_state <= spi_pkg::RD_IDLE;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rdata    <= '0;
            rresp    <= `SPI_RESP_OKAY;
        end else begin
            case (rd_state)
                spi_pkg::RD_IDLE: begin
                    arready <= 1'b1;
                    if (arvalid && arready) begin
                        arready  <= 1'b0;
                        rd_state <= spi_pkg::RD_FETCH;
                    end
                end
                spi_pkg::RD_FETCH: begin
                    case (spi_pkg::reg_addr_e'(araddr_q))
                        spi_pkg::REG_TX_DATA: rdata <= tx_data_q;
                        spi_pkg::REG_MODE:    rdata <= {{(`SPI_DATA_WIDTH-2){1'b0}}, mode_q};
                        spi_pkg::REG_CTRL:    rdata <= '0;
                        spi_pkg::REG_RX_DATA: rdata <= status.rx_data;
                        spi_pkg::REG_STATUS:  rdata <= {{(`SPI_DATA_WIDTH-2){1'b0}},
                                                        status.busy, done_sticky};
                        default:              rdata <= '0;
                    endcase
                    rresp    <= rd_mapped ? `SPI_RESP_OKAY : `SPI_RESP_SLVERR;
                    rd_state <= spi_pkg::RD_RESP;
                end
                spi_pkg::RD_RESP: begin
                    if (!rvalid) begin
                        rvalid <= 1'b1;
                    end else if (rready) begin
                        rvalid   <= 1'b0;
                        rd_state <= spi_pkg::RD_IDLE;
                    end
                end
                default: rd_state <= spi_pkg::RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (rd_state == spi_pkg::RD_IDLE && arvalid && arready) begin
            araddr_q <= araddr;
        end
    end

endmodule

// File: spi_dual_engine.sv
// SPI shift engine for single, dual transmit and dual receive byte transfers
`timescale 1ns/1ns
`include "spi_defines.svh"

module spi_dual_engine (
    input  logic                 axi_aclk,
    input  logic                 axi_aresetn,
    input  spi_pkg::spi_cmd_t    cmd,
    input  logic [1:0]           io_in,
    output spi_pkg::spi_status_t status,
    output logic                 sck,
    output logic                 cs_n,
    output logic [1:0]           io_out,
    output logic [1:0]           io_oe
);

    spi_pkg::spi_state_e        state;
    spi_pkg::spi_mode_e         mode_q;
    logic [2:0]                 bit_cnt;
    logic [`SPI_DATA_WIDTH-1:0] tx_shift;
    logic [`SPI_DATA_WIDTH-1:0] rx_shift;
    logic [`SPI_DATA_WIDTH-1:0] rx_hold;
    logic                       done_q;
    logic                       load;
    logic                       sck_rise;
    logic                       sck_fall;
    logic                       last_fall;
    logic                       dual_new;
    logic                       dual_q;

    function automatic logic is_dual(input spi_pkg::spi_mode_e m);
        return (m == spi_pkg::MODE_DUAL_TX) || (m == spi_pkg::MODE_DUAL_RX);
    endfunction

    function automatic logic [1:0] oe_for(input spi_pkg::spi_mode_e m);
        case (m)
            spi_pkg::MODE_DUAL_TX: return 2'b11;
            spi_pkg::MODE_DUAL_RX: return 2'b00;
            default:               return 2'b01;
        endcase
    endfunction

    assign load      = (state == spi_pkg::SPI_IDLE) && cmd.start;
    assign dual_new  = is_dual(cmd.mode);
    assign dual_q    = is_dual(mode_q);

    // sck is registered, so its current level tells which edge comes next
    assign sck_rise  = (state == spi_pkg::SPI_SHIFT) && !sck;
    assign sck_fall  = (state == spi_pkg::SPI_SHIFT) && sck;
    assign last_fall = sck_fall && (bit_cnt == 3'd0);

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            state   <= spi_pkg::SPI_IDLE;
            mode_q  <= spi_pkg::MODE_SINGLE;
            bit_cnt <= 3'd0;
            sck     <= 1'b0;
            cs_n    <= 1'b1;
            io_oe   <= 2'b00;
            done_q  <= 1'b0;
            rx_hold <= '0;
        end else begin
            done_q <= 1'b0;
            if (load) begin
                state   <= spi_pkg::SPI_SHIFT;
                mode_q  <= cmd.mode;
                bit_cnt <= dual_new ? 3'd3 : 3'd7;
                sck     <= 1'b0;
                cs_n    <= 1'b0;
                io_oe   <= oe_for(cmd.mode);
            end else if (state == spi_pkg::SPI_SHIFT) begin
                sck <= ~sck;
                if (last_fall) begin
                    state   <= spi_pkg::SPI_IDLE;
                    cs_n    <= 1'b1;
                    io_oe   <= 2'b00;
                    rx_hold <= rx_shift;
                    done_q  <= 1'b1;
                end else if (sck_fall) begin
                    bit_cnt <= bit_cnt - 3'd1;
                end
            end
        end
    end

    // First bits go out with cs_n, later ones on each falling sck
    always_ff @(posedge axi_aclk) begin
        if (load) begin
            if (dual_new) begin
                io_out   <= cmd.tx_data[7:6];
                tx_shift <= {cmd.tx_data[5:0], 2'b00};
            end else begin
                io_out   <= {1'b0, cmd.tx_data[7]};
                tx_shift <= {cmd.tx_data[6:0], 1'b0};
            end
        end else if (sck_fall && !last_fall) begin
            if (dual_q) begin
                io_out   <= tx_shift[7:6];
                tx_shift <= {tx_shift[5:0], 2'b00};
            end else begin
                io_out   <= {1'b0, tx_shift[7]};
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    // io1 is the high bit of each pair, single mode listens on io1 only
    always_ff @(posedge axi_aclk) begin
        if (sck_rise) begin
            if (dual_q) begin
                rx_shift <= {rx_shift[5:0], io_in[1], io_in[0]};
            end else begin
                rx_shift <= {rx_shift[6:0], io_in[1]};
            end
        end
    end

    assign status = '{
        rx_data: rx_hold,
        done:    done_q,
        busy:    (state == spi_pkg::SPI_SHIFT)
    };

endmodule

// File: spi_axi_top.sv
// Top level of the AXI4-Lite SPI master, joins the register block, the engine and the pads
`timescale 1ns/1ns
`include "spi_defines.svh"

module spi_axi_top (
    input  logic                       axi_aclk,
    input  logic                       axi_aresetn,

    input  logic [`SPI_ADDR_WIDTH-1:0] s_axi_awaddr,
    input  logic                       s_axi_awvalid,
    output logic                       s_axi_awready,

    input  logic [`SPI_DATA_WIDTH-1:0] s_axi_wdata,
    input  logic [`SPI_STRB_WIDTH-1:0] s_axi_wstrb,
    input  logic                       s_axi_wvalid,
    output logic                       s_axi_wready,

    output logic [1:0]                 s_axi_bresp,
    output logic                       s_axi_bvalid,
    input  logic                       s_axi_bready,

    input  logic [`SPI_ADDR_WIDTH-1:0] s_axi_araddr,
    input  logic                       s_axi_arvalid,
    output logic                       s_axi_arready,

    output logic [`SPI_DATA_WIDTH-1:0] s_axi_rdata,
    output logic [1:0]                 s_axi_rresp,
    output logic                       s_axi_rvalid,
    input  logic                       s_axi_rready,

    output logic                       sck,
    output logic                       cs_n,
    inout  wire                        io0,
    inout  wire                        io1
);

    spi_pkg::spi_cmd_t    cmd;
    spi_pkg::spi_status_t status;
    logic [1:0]           io_out;
    logic [1:0]           io_oe;
    logic [1:0]           io_in;

    axi_lite_regs axi_lite_regs_inst (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .awaddr      (s_axi_awaddr),
        .awvalid     (s_axi_awvalid),
        .awready     (s_axi_awready),
        .wdata       (s_axi_wdata),
        .wstrb       (s_axi_wstrb),
        .wvalid      (s_axi_wvalid),
        .wready      (s_axi_wready),
        .bresp       (s_axi_bresp),
        .bvalid      (s_axi_bvalid),
        .bready      (s_axi_bready),
        .araddr      (s_axi_araddr),
        .arvalid     (s_axi_arvalid),
        .arready     (s_axi_arready),
        .rdata       (s_axi_rdata),
        .rresp       (s_axi_rresp),
        .rvalid      (s_axi_rvalid),
        .rready      (s_axi_rready),
        .status      (status),
        .cmd         (cmd)
    );

    spi_dual_engine spi_dual_engine_inst (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .cmd         (cmd),
        .io_in       (io_in),
        .status      (status),
        .sck         (sck),
        .cs_n        (cs_n),
        .io_out      (io_out),
        .io_oe       (io_oe)
    );

    // Pad drivers, io1 is bit 1 of the engine's pair
    assign io0   = io_oe[0] ? io_out[0] : 1'bz;
    assign io1   = io_oe[1] ? io_out[1] : 1'bz;
    assign io_in = {io1, io0};

endmodule

// File: spi_axi_asserts.sv
// Protocol assertions for the SPI master, bound into the top level for simulation
`timescale 1ns/1ns

module spi_axi_asserts (
    input logic       axi_aclk,
    input logic       axi_aresetn,
    input logic       busy,
    input logic       sck,
    input logic       cs_n,
    input logic [1:0] io_oe,
    input logic       bvalid,
    input logic       bready,
    input logic       rvalid,
    input logic       rready
);

    int assert_failures = 0;

    cs_high_when_idle: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        !busy |-> cs_n)
        else begin
            $error("cs_n is low while the engine is not busy");
            assert_failures++;
        end

    // The last falling sck edge lands together with cs_n going high
    sck_only_in_frame: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        (sck != $past(sck)) |-> !$past(cs_n))
        else begin
            $error("sck toggled outside a cs_n low period");
            assert_failures++;
        end

    bvalid_held: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        bvalid && !bready |=> bvalid)
        else begin
            $error("bvalid dropped before bready");
            assert_failures++;
        end

    rvalid_held: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        rvalid && !rready |=> rvalid)
        else begin
            $error("rvalid dropped before rready");
            assert_failures++;
        end

    pads_released: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        cs_n |-> (io_oe == 2'b00))
        else begin
            $error("io_oe is set while cs_n is high");
            assert_failures++;
        end

endmodule

bind spi_axi_top spi_axi_asserts spi_axi_asserts_inst (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .busy        (status.busy),
    .sck         (sck),
    .cs_n        (cs_n),
    .io_oe       (io_oe),
    .bvalid      (s_axi_bvalid),
    .bready      (s_axi_bready),
    .rvalid      (s_axi_rvalid),
    .rready      (s_axi_rready)
);

// File: spi_axi_tb.sv
// Testbench for the AXI4-Lite SPI master, drives the bus and models an SPI slave on the pads
`timescale 1ns/1ns
`include "spi_defines.svh"

module spi_axi_tb;

    localparam int TEST_COUNT      = 6;
    localparam int CYCLES_PER_TEST = 300;
    localparam int TIMEOUT_CYCLES  = 2 * TEST_COUNT * CYCLES_PER_TEST + 400;

    logic                       axi_aclk;
    logic                       axi_aresetn;
    logic [`SPI_ADDR_WIDTH-1:0] s_axi_awaddr;
    logic                       s_axi_awvalid;
    logic                       s_axi_awready;
    logic [`SPI_DATA_WIDTH-1:0] s_axi_wdata;
    logic [`SPI_STRB_WIDTH-1:0] s_axi_wstrb;
    logic                       s_axi_wvalid;
    logic                       s_axi_wready;
    logic [1:0]                 s_axi_bresp;
    logic                       s_axi_bvalid;
    logic                       s_axi_bready;
    logic [`SPI_ADDR_WIDTH-1:0] s_axi_araddr;
    logic                       s_axi_arvalid;
    logic                       s_axi_arready;
    logic [`SPI_DATA_WIDTH-1:0] s_axi_rdata;
    logic [1:0]                 s_axi_rresp;
    logic                       s_axi_rvalid;
    logic                       s_axi_rready;
    logic                       sck;
    logic                       cs_n;
    wire                        io0;
    wire                        io1;

    // Slave model state
    spi_pkg::spi_mode_e slave_mode;
    logic               slave_dual;
    logic [1:0]         slave_oe;
    logic [1:0]         slave_out;
    logic [7:0]         slave_byte;
    logic [7:0]         slave_shift;
    logic [7:0]         seen_bits;
    int                 slave_steps;
    int                 frames;
    integer             seed;

    int errors;
    int checks;
    int tests_done;
    int cycle_count;

    spi_axi_top spi_axi_top_inst (.*);

    initial axi_aclk = 1'b0;
    always #10 axi_aclk = ~axi_aclk;

    always @(posedge axi_aclk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a handshake or transfer never completed",
                     cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    // Slave drives only the pads that the mode leaves to it
    assign slave_dual = (slave_mode == spi_pkg::MODE_DUAL_TX) ||
                        (slave_mode == spi_pkg::MODE_DUAL_RX);
    assign io0 = slave_oe[0] ? slave_out[0] : 1'bz;
    assign io1 = slave_oe[1] ? slave_out[1] : 1'bz;

    task automatic drive_slave_bits();
        if (slave_dual) begin
            slave_out   = slave_shift[7:6];
            slave_shift = {slave_shift[5:0], 2'b00};
        end else begin
            slave_out   = {slave_shift[7], 1'b0};
            slave_shift = {slave_shift[6:0], 1'b0};
        end
        slave_steps--;
    endtask

    always @(negedge cs_n) begin
        frames++;
        slave_byte  = $random(seed);
        slave_shift = slave_byte;
        seen_bits   = 8'h00;
        slave_steps = slave_dual ? 4 : 8;
        case (slave_mode)
            spi_pkg::MODE_DUAL_TX: slave_oe = 2'b00;
            spi_pkg::MODE_DUAL_RX: slave_oe = 2'b11;
            default:               slave_oe = 2'b10;
        endcase
        drive_slave_bits();
    end

    always @(negedge sck) begin
        if (slave_steps > 0) begin
            drive_slave_bits();
        end
    end

    always @(posedge cs_n) slave_oe = 2'b00;

    always @(posedge sck) begin
        if (slave_dual) begin
            seen_bits = {seen_bits[5:0], io1, io0};
        end else begin
            seen_bits = {seen_bits[6:0], io0};
        end
    end

    task automatic check_equal(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic axi_write(input logic [`SPI_ADDR_WIDTH-1:0] addr,
                             input logic [`SPI_DATA_WIDTH-1:0] data,
                             input int stall, output logic [1:0] resp);
        @(posedge axi_aclk);
        #2;
        s_axi_awaddr  = addr;
        s_axi_awvalid = 1'b1;
        s_axi_wdata   = data;
        s_axi_wvalid  = 1'b1;
        @(negedge axi_aclk);
        while (!(s_axi_awready && s_axi_wready)) @(negedge axi_aclk);
        @(posedge axi_aclk);
        #2;
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        @(negedge axi_aclk);
        while (!s_axi_bvalid) @(negedge axi_aclk);
        repeat (stall) begin
            @(negedge axi_aclk);
            check_equal("s_axi_bvalid", s_axi_bvalid, 8'h01);
        end
        @(posedge axi_aclk);
        #2;
        s_axi_bready = 1'b1;
        @(negedge axi_aclk);
        resp = s_axi_bresp;
        @(posedge axi_aclk);
        #2;
        s_axi_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [`SPI_ADDR_WIDTH-1:0] addr, input int stall,
                            output logic [`SPI_DATA_WIDTH-1:0] data, output logic [1:0] resp);
        @(posedge axi_aclk);
        #2;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        @(negedge axi_aclk);
        while (!s_axi_arready) @(negedge axi_aclk);
        @(posedge axi_aclk);
        #2;
        s_axi_arvalid = 1'b0;
        @(negedge axi_aclk);
        while (!s_axi_rvalid) @(negedge axi_aclk);
        repeat (stall) begin
            @(negedge axi_aclk);
            check_equal("s_axi_rvalid", s_axi_rvalid, 8'h01);
        end
        @(posedge axi_aclk);
        #2;
        s_axi_rready = 1'b1;
        @(negedge axi_aclk);
        data = s_axi_rdata;
        resp = s_axi_rresp;
        @(posedge axi_aclk);
        #2;
        s_axi_rready = 1'b0;
    endtask

    task automatic wait_for_done();
        logic [7:0] st;
        logic [1:0] resp;
        st = 8'h00;
        while (st[`SPI_STATUS_DONE_BIT] !== 1'b1) axi_read(spi_pkg::REG_STATUS, 0, st, resp);
    endtask

    task automatic run_transfer(input spi_pkg::spi_mode_e mode, input logic [7:0] tx,
                                output logic [7:0] rx);
        logic [1:0] resp;
        slave_mode = mode;
        axi_write(spi_pkg::REG_MODE, {6'd0, mode}, 0, resp);
        axi_write(spi_pkg::REG_TX_DATA, tx, 0, resp);
        axi_write(spi_pkg::REG_CTRL, 8'h01, 0, resp);
        wait_for_done();
        axi_read(spi_pkg::REG_RX_DATA, 0, rx, resp);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_done++;
        if (errors == errors_before) begin
            $display("Test %0d %s: passed", tests_done, name);
        end else begin
            $display("Test %0d %s: %0d errors", tests_done, name, errors - errors_before);
        end
    endtask

    initial begin
        logic [7:0] data;
        logic [1:0] resp;
        int         mark;
        int         idx;
        int         frames_before;
        int         total_errors;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '1;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        axi_aresetn   = 1'b0;
        slave_mode    = spi_pkg::MODE_SINGLE;
        slave_oe      = 2'b00;
        slave_out     = 2'b00;
        slave_steps   = 0;
        frames        = 0;
        seed          = 32'h3bfb;
        errors        = 0;
        checks        = 0;
        tests_done    = 0;
        cycle_count   = 0;
        repeat (8) @(posedge axi_aclk);
        #2;
        axi_aresetn = 1'b1;

        mark = errors;
        for (idx = 0; idx < 5; idx++) begin
            axi_read(idx[3:0], 0, data, resp);
            check_equal("s_axi_rdata", data, 8'h00);
        end
        axi_write(spi_pkg::REG_TX_DATA, 8'ha5, 0, resp);
        check_equal("s_axi_bresp", resp, `SPI_RESP_OKAY);
        axi_write(spi_pkg::REG_MODE, 8'h02, 0, resp);
        axi_write(spi_pkg::REG_CTRL, 8'hfe, 0, resp);
        axi_read(spi_pkg::REG_TX_DATA, 0, data, resp);
        check_equal("tx_data", data, 8'ha5);
        check_equal("s_axi_rresp", resp, `SPI_RESP_OKAY);
        axi_read(spi_pkg::REG_MODE, 0, data, resp);
        check_equal("mode", data, 8'h02);
        axi_read(spi_pkg::REG_CTRL, 0, data, resp);
        check_equal("ctrl", data, 8'h00);
        finish_test("register access", mark);

        mark = errors;
        run_transfer(spi_pkg::MODE_SINGLE, 8'h96, data);
        check_equal("io0 bits", seen_bits, 8'h96);
        check_equal("rx_data", data, slave_byte);
        finish_test("single mode", mark);

        mark = errors;
        run_transfer(spi_pkg::MODE_DUAL_TX, 8'h5c, data);
        check_equal("io1/io0 pairs", seen_bits, 8'h5c);
        check_equal("rx_data", data, 8'h5c);
        finish_test("dual transmit mode", mark);

        // Any DUT drive on the pads would corrupt the slave's pairs
        mark = errors;
        run_transfer(spi_pkg::MODE_DUAL_RX, 8'hff, data);
        check_equal("io1/io0 pairs", seen_bits, slave_byte);
        check_equal("rx_data", data, slave_byte);
        finish_test("dual receive mode", mark);

        mark = errors;
        axi_write(4'd5, 8'h77, 0, resp);
        check_equal("s_axi_bresp", resp, `SPI_RESP_SLVERR);
        axi_read(4'd5, 0, data, resp);
        check_equal("s_axi_rresp", resp, `SPI_RESP_SLVERR);
        check_equal("s_axi_rdata", data, 8'h00);
        axi_read(spi_pkg::REG_TX_DATA, 0, data, resp);
        check_equal("tx_data", data, 8'hff);
        axi_read(spi_pkg::REG_MODE, 0, data, resp);
        check_equal("mode", data, 8'h02);
        slave_mode    = spi_pkg::MODE_SINGLE;
        frames_before = frames;
        axi_write(spi_pkg::REG_MODE, 8'h00, 0, resp);
        axi_write(spi_pkg::REG_CTRL, 8'h01, 0, resp);
        axi_write(spi_pkg::REG_CTRL, 8'h01, 0, resp);
        wait_for_done();
        repeat (40) @(posedge axi_aclk);
        check_equal("cs_n low periods", frames - frames_before, 8'h01);
        finish_test("errors and dropped start", mark);

        mark = errors;
        axi_write(spi_pkg::REG_TX_DATA, 8'h3c, 5, resp);
        check_equal("s_axi_bresp", resp, `SPI_RESP_OKAY);
        axi_read(spi_pkg::REG_TX_DATA, 6, data, resp);
        check_equal("s_axi_rdata", data, 8'h3c);
        check_equal("s_axi_rresp", resp, `SPI_RESP_OKAY);
        finish_test("back-pressure", mark);

        total_errors = errors + spi_axi_top_inst.spi_axi_asserts_inst.assert_failures;
        $display("Tests: %0d, checks: %0d, errors: %0d", tests_done, checks, total_errors);
        if (total_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
spi_pkg.sv
axi_lite_regs.sv
spi_dual_engine.sv
spi_axi_top.sv
spi_axi_asserts.sv
spi_axi_tb.sv

// File: Bender.yml
package:
  name: spi_axi

export_include_dirs:
  - .

sources:
  - spi_pkg.sv
  - axi_lite_regs.sv
  - spi_dual_engine.sv
  - spi_axi_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - spi_axi_asserts.sv
      - spi_axi_tb.sv
